//--- verif/decode_golden.txt
# Columns: name, lane 0 word, lane 1 word, group count, then per group its lane mask
# Each lane set in the mask adds its control word and destination register, lane 0 first
rtype_add_sub 00221820 00853022 1 3 1c001 03 1c002 06
rtype_or_xor 00e84825 014b6026 1 3 1c004 09 1c005 0c
rtype_slt_sll 01ae782a 00119100 1 3 1c006 0f 1c009 12
imm_addi_lui 20220005 3c031234 1 3 14001 02 14008 03
imm_xori_sltiu 388500ff 2cc70009 1 3 14005 05 14007 07
mem_lw_sw 8d280004 ad6a0008 1 3 14c01 08 05001 00
flow_beq_j 10220010 08000100 1 3 00042 00 00020 00
flow_bne_reserved 14640008 fc000000 1 3 00042 00 00010 00
raw_rd 00221820 00642824 2 1 1c001 03 2 1c003 05
raw_rt 34060007 ace60000 2 1 14004 06 2 05001 00
raw_sltu_andi 0022502b 314b000f 2 1 1c007 0a 2 14003 0b
zero_reg 24200001 28020003 1 3 14001 00 14006 02
hilo_mthi_mfhi 00800011 00002810 2 1 00380 00 2 1a100 05
hilo_mult_mflo 00c70018 00004012 2 1 0020a 00 2 1a000 08
hilo_multu_mtlo 00220019 00600013 1 3 0020b 00 00280 00

//--- files.f
+incdir+include
source/isaPkg.sv
source/ctrlPkg.sv
source/bundleLatch.sv
source/decodeLane.sv
source/issueCollector.sv
source/decodeStage.sv
verif/decodeStageTb.sv

//--- Bender.yml
package:
  name: decode_stage

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/isaPkg.sv
      - source/ctrlPkg.sv
      - source/bundleLatch.sv
      - source/decodeLane.sv
      - source/issueCollector.sv
      - source/decodeStage.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/decodeStageTb.sv

//--- verif/decodeStageTb.sv
`timescale 1ns/100ps
`include "decode_params.svh"

module decodeStageTb;

    localparam int MAX_REC = 32;
    localparam int MAX_TOK = 6;
    // Cycles allowed between strobe or pulse and the next pulse
    localparam int PULSE_WAIT = 6;
    localparam int CTRL_W = $bits(ctrlPkg::ctrlWordT);

    logic                   clk;
    logic                   reset;
    logic                   inValid;
    logic [31:0]            bundleWords [0:`LANES-1];
    logic                   busy;
    logic                   issueValid;
    ctrlPkg::laneMaskT      issueMask;
    ctrlPkg::ctrlWordT      ctrlOut [0:`LANES-1];
    logic [`REG_ADDR_W-1:0] destOut [0:`LANES-1];

    // One golden record per data line
    reg [8*32-1:0] recName [0:MAX_REC-1];
    logic [31:0]   recWord [0:MAX_REC-1][0:1];
    int            recGroups [0:MAX_REC-1];
    logic [31:0]   recTok [0:MAX_REC-1][0:MAX_TOK-1];
    int            recToks [0:MAX_REC-1];
    int            recCount;
    logic          loaded;

    logic [31:0] rngState;
    int          testErrs;
    int          passCount;
    int          failCount;

    initial clk = 1'b0;
    always #2 clk = ~clk;

    decodeStage dut_i (
        .clk         (clk),
        .reset       (reset),
        .inValid     (inValid),
        .bundleWords (bundleWords),
        .busy        (busy),
        .issueValid  (issueValid),
        .issueMask   (issueMask),
        .ctrlOut     (ctrlOut),
        .destOut     (destOut)
    );

    ////////////////////
    // Helpers
    ////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Drive point just past the rising edge
    task automatic nextCycle();
        @(posedge clk);
        #0.5;
    endtask

    task automatic reportMismatch(input string what, input logic [31:0] expVal,
                                  input logic [31:0] gotVal);
        $display("FAILED at %0.1f ns: %s expected %h got %h", $realtime, what, expVal, gotVal);
        testErrs++;
    endtask

    task automatic finishTest(input string name);
        if (testErrs == 0) begin
            $display("PASSED %s", name);
            passCount++;
        end else begin
            $display("FAILED at %0.1f ns: test %s had %0d errors", $realtime, name, testErrs);
            failCount++;
        end
    endtask

    ////////////////////
    // Golden file
    ////////////////////

    task automatic loadGolden();
        int             fd;
        int             n;
        reg [8*160-1:0] lineBuf;
        reg [8*32-1:0]  nameBuf;
        logic [31:0]    w0;
        logic [31:0]    w1;
        int             groups;
        logic [31:0]    tok [0:MAX_TOK-1];
        fd = $fopen("verif/decode_golden.txt", "r");
        if (fd == 0) begin
            $display("Could not open golden file verif/decode_golden.txt");
            failCount++;
            return;
        end
        while (!$feof(fd)) begin
            lineBuf = '0;
            n = $fgets(lineBuf, fd);
            n = $sscanf(lineBuf, "%s %h %h %d %h %h %h %h %h %h", nameBuf, w0, w1, groups,
                        tok[0], tok[1], tok[2], tok[3], tok[4], tok[5]);
            // Comment and blank lines never reach the first group
            if (n >= 7 && recCount < MAX_REC) begin
                recName[recCount] = nameBuf;
                recWord[recCount][0] = w0;
                recWord[recCount][1] = w1;
                recGroups[recCount] = groups;
                recToks[recCount] = n - 4;
                for (int i = 0; i < MAX_TOK; i++) begin
                    recTok[recCount][i] = tok[i];
                end
                recCount++;
            end
        end
        $fclose(fd);
    endtask

    ////////////////////
    // One bundle
    ////////////////////

    task automatic runRecord(input int r);
        string       name;
        int          p;
        int          lat;
        bit          missing;
        logic [31:0] expMask;
        logic [31:0] expCtrl;
        logic [31:0] expDest;
        name = $sformatf("%0s", recName[r]);
        testErrs = 0;
        missing = 1'b0;
        p = 0;
        inValid = 1'b1;
        bundleWords[0] = recWord[r][0];
        bundleWords[1] = recWord[r][1];
        nextCycle();
        if (busy !== 1'b1) begin
            reportMismatch($sformatf("%s busy after strobe", name), 1, busy);
        end
        // Strobe stays up with reserved words until the last pulse and busy drops it
        for (int k = 0; k < `LANES; k++) begin
            bundleWords[k] = 32'hfc000000;
        end
        lat = 1;
        for (int g = 0; g < recGroups[r] && !missing; g++) begin
            do begin
                nextCycle();
                lat++;
            end while (issueValid !== 1'b1 && lat < PULSE_WAIT);
            if (issueValid !== 1'b1) begin
                $display("No issue pulse for group %0d of %s within %0d cycles",
                         g, name, PULSE_WAIT);
                testErrs++;
                missing = 1'b1;
            end else begin
                // First group at t+2 and the rest back to back
                if (lat != ((g == 0) ? 2 : 1)) begin
                    reportMismatch($sformatf("%s group %0d latency", name, g),
                                   (g == 0) ? 2 : 1, lat);
                end
                expMask = recTok[r][p];
                p++;
                if (issueMask !== expMask[`LANES-1:0]) begin
                    reportMismatch($sformatf("%s group %0d mask", name, g), expMask, issueMask);
                end
                if (busy !== 1'b1) begin
                    reportMismatch($sformatf("%s group %0d busy", name, g), 1, busy);
                end
                for (int k = 0; k < `LANES; k++) begin
                    // Lanes left out of the group read as zero
                    expCtrl = '0;
                    expDest = '0;
                    if (expMask[k] && p + 1 < MAX_TOK) begin
                        expCtrl = recTok[r][p];
                        expDest = recTok[r][p + 1];
                        p += 2;
                    end
                    if (ctrlOut[k] !== expCtrl[CTRL_W-1:0]) begin
                        reportMismatch($sformatf("%s group %0d lane %0d ctrl", name, g, k),
                                       expCtrl, ctrlOut[k]);
                    end
                    if (destOut[k] !== expDest[`REG_ADDR_W-1:0]) begin
                        reportMismatch($sformatf("%s group %0d lane %0d dest", name, g, k),
                                       expDest, destOut[k]);
                    end
                end
                lat = 0;
            end
        end
        inValid = 1'b0;
        if (!missing && p != recToks[r]) begin
            $display("Golden record %s has %0d fields for its groups, %0d were used",
                     name, recToks[r], p);
            testErrs++;
        end
        if (!missing) begin
            // Idle one cycle after the last pulse
            nextCycle();
            if (issueValid !== 1'b0) begin
                reportMismatch($sformatf("%s extra issue pulse", name), 0, issueValid);
            end
            if (busy !== 1'b0) begin
                reportMismatch($sformatf("%s busy after issue", name), 0, busy);
            end
        end
        for (int c = 0; c < PULSE_WAIT && busy === 1'b1; c++) begin
            nextCycle();
        end
        finishTest(name);
    endtask

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        reset = 1'b1;
        inValid = 1'b0;
        for (int k = 0; k < `LANES; k++) begin
            bundleWords[k] = '0;
        end
        rngState = 32'h45a8d31c;
        recCount = 0;
        passCount = 0;
        failCount = 0;
        loaded = 1'b0;
        loadGolden();
        loaded = 1'b1;
        repeat (16) nextCycle();
        // Outputs cleared by reset
        testErrs = 0;
        if (issueValid !== 1'b0) begin
            reportMismatch("issueValid after reset", 0, issueValid);
        end
        if (issueMask !== '0) begin
            reportMismatch("issueMask after reset", 0, issueMask);
        end
        if (busy !== 1'b0) begin
            reportMismatch("busy after reset", 0, busy);
        end
        for (int k = 0; k < `LANES; k++) begin
            if (ctrlOut[k] !== '0) begin
                reportMismatch($sformatf("ctrlOut lane %0d after reset", k), 0, ctrlOut[k]);
            end
        end
        finishTest("reset_state");
        reset = 1'b0;
        for (int r = 0; r < recCount; r++) begin
            // Idle gap of 0 to 3 cycles
            rngState = xorshift32(rngState);
            repeat (rngState[1:0]) nextCycle();
            runRecord(r);
        end
        $display("Tests passed %0d, failed %0d", passCount, failCount);
        if (failCount == 0 && recCount > 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // Watchdog sized from the record count
    initial begin
        wait (loaded === 1'b1);
        repeat (recCount * 10 + 40) @(posedge clk);
        $display("Timeout after %0d cycles, the run did not complete", recCount * 10 + 40);
        $display("Result: FAILED");
        $finish;
    end

endmodule

//--- source/decodeStage.sv
`timescale 1ns/100ps
`include "decode_params.svh"

module decodeStage (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   inValid,
    input  logic [31:0]            bundleWords [0:`LANES-1],
    output logic                   busy,
    output logic                   issueValid,
    output ctrlPkg::laneMaskT      issueMask,
    output ctrlPkg::ctrlWordT      ctrlOut [0:`LANES-1],
    output logic [`REG_ADDR_W-1:0] destOut [0:`LANES-1]
);

    logic [31:0]            heldWords [0:`LANES-1];
    logic                   held;
    logic                   pending;
    ctrlPkg::ctrlWordT      laneCtrl [0:`LANES-1];
    logic [`REG_ADDR_W-1:0] laneDest [0:`LANES-1];
    logic [`REG_ADDR_W-1:0] laneSrcA [0:`LANES-1];
    logic [`REG_ADDR_W-1:0] laneSrcB [0:`LANES-1];
    ctrlPkg::laneMaskT      laneUsesA;
    ctrlPkg::laneMaskT      laneUsesB;
    ctrlPkg::laneMaskT      laneReadsHilo;

    // Upstream holds off from capture until the last issue pulse
    assign busy = held | pending;

    bundleLatch latch_i (
        .clk         (clk),
        .reset       (reset),
        .inValid     (inValid),
        .bundleWords (bundleWords),
        .pending     (pending),
        .heldWords   (heldWords),
        .held        (held)
    );

    ////////////////////
    // Decode lanes
    ////////////////////

    genvar laneIdx;
    generate
        for (laneIdx = 0; laneIdx < `LANES; laneIdx++) begin : laneGen
            decodeLane lane_i (
                .instrWord (heldWords[laneIdx]),
                .ctrl      (laneCtrl[laneIdx]),
                .destReg   (laneDest[laneIdx]),
                .srcA      (laneSrcA[laneIdx]),
                .srcB      (laneSrcB[laneIdx]),
                .usesA     (laneUsesA[laneIdx]),
                .usesB     (laneUsesB[laneIdx]),
                .readsHilo (laneReadsHilo[laneIdx])
            );
        end
    endgenerate

    // Held pulse kicks off issue
    issueCollector collector_i (
        .clk        (clk),
        .reset      (reset),
        .start      (held),
        .ctrl       (laneCtrl),
        .destReg    (laneDest),
        .srcA       (laneSrcA),
        .srcB       (laneSrcB),
        .usesA      (laneUsesA),
        .usesB      (laneUsesB),
        .readsHilo  (laneReadsHilo),
        .issueValid (issueValid),
        .issueMask  (issueMask),
        .ctrlOut    (ctrlOut),
        .destOut    (destOut),
        .pending    (pending)
    );

endmodule

//--- source/issueCollector.sv
`timescale 1ns/100ps
`include "decode_params.svh"

module issueCollector (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   start,
    input  ctrlPkg::ctrlWordT      ctrl [0:`LANES-1],
    input  logic [`REG_ADDR_W-1:0] destReg [0:`LANES-1],
    input  logic [`REG_ADDR_W-1:0] srcA [0:`LANES-1],
    input  logic [`REG_ADDR_W-1:0] srcB [0:`LANES-1],
    input  ctrlPkg::laneMaskT      usesA,
    input  ctrlPkg::laneMaskT      usesB,
    input  ctrlPkg::laneMaskT      readsHilo,
    output logic                   issueValid,
    output ctrlPkg::laneMaskT      issueMask,
    output ctrlPkg::ctrlWordT      ctrlOut [0:`LANES-1],
    output logic [`REG_ADDR_W-1:0] destOut [0:`LANES-1],
    output logic                   pending
);

    ctrlPkg::laneMaskT remMask;
    ctrlPkg::laneMaskT effRemaining;
    ctrlPkg::laneMaskT blocked;
    ctrlPkg::laneMaskT issueNow;
    logic              stopScan;

    // A fresh bundle makes every lane outstanding
    assign effRemaining = start ? '1 : remMask;

    ////////////////////
    // Hazard scan
    ////////////////////

    always_comb begin
        blocked = '0;
        issueNow = '0;
        stopScan = 1'b0;
        for (int k = 0; k < `LANES; k++) begin
            // Only earlier lanes still outstanding can block
            for (int j = 0; j < k; j++) begin
                if (effRemaining[j]) begin
                    if (destReg[j] != '0 && usesA[k] && srcA[k] == destReg[j]) begin
                        blocked[k] = 1'b1;
                    end
                    if (destReg[j] != '0 && usesB[k] && srcB[k] == destReg[j]) begin
                        blocked[k] = 1'b1;
                    end
                    // HI/LO written ahead of a read
                    if (ctrl[j].hiloWrite && readsHilo[k]) begin
                        blocked[k] = 1'b1;
                    end
                end
            end
            // Prefix ends at the first blocked outstanding lane
            if (effRemaining[k] && !stopScan) begin
                if (blocked[k]) begin
                    stopScan = 1'b1;
                end else begin
                    issueNow[k] = 1'b1;
                end
            end
        end
    end

    ////////////////////
    // Issue registers
    ////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            remMask <= '0;
            pending <= 1'b0;
            issueValid <= 1'b0;
            issueMask <= '0;
            for (int k = 0; k < `LANES; k++) begin
                ctrlOut[k] <= '0;
            end
        end else begin
            remMask <= effRemaining & ~issueNow;
            // Stays up through the last issue pulse
            pending <= |effRemaining;
            issueValid <= |issueNow;
            issueMask <= issueNow;
            for (int k = 0; k < `LANES; k++) begin
                ctrlOut[k] <= issueNow[k] ? ctrl[k] : '0;
            end
        end
    end

    // Destination copies follow the mask
    always_ff @(posedge clk) begin
        for (int k = 0; k < `LANES; k++) begin
            destOut[k] <= issueNow[k] ? destReg[k] : '0;
        end
    end

endmodule

//--- source/decodeLane.sv
`timescale 1ns/100ps
`include "decode_params.svh"

module decodeLane (
    input  logic [31:0]             instrWord,
    output ctrlPkg::ctrlWordT       ctrl,
    output logic [`REG_ADDR_W-1:0]  destReg,
    output logic [`REG_ADDR_W-1:0]  srcA,
    output logic [`REG_ADDR_W-1:0]  srcB,
    output logic                    usesA,
    output logic                    usesB,
    output logic                    readsHilo
);

    isaPkg::opcodeE         opcode;
    isaPkg::functE          funct;
    logic [`REG_ADDR_W-1:0] rdField;
    logic                   isShift;

    // ALU op for plain R-type arithmetic
    function automatic ctrlPkg::aluOpE rAluOp(input isaPkg::functE f);
        case (f)
            isaPkg::ADD, isaPkg::ADDU: return ctrlPkg::ALU_ADD;
            isaPkg::SUB, isaPkg::SUBU: return ctrlPkg::ALU_SUB;
            isaPkg::AND:               return ctrlPkg::ALU_AND;
            isaPkg::OR:                return ctrlPkg::ALU_OR;
            isaPkg::XOR:               return ctrlPkg::ALU_XOR;
            isaPkg::SLT:               return ctrlPkg::ALU_SLT;
            isaPkg::SLTU:              return ctrlPkg::ALU_SLTU;
            isaPkg::SLL, isaPkg::SRL,
            isaPkg::SRA:               return ctrlPkg::ALU_SHIFT;
            default:                   return ctrlPkg::ALU_NONE;
        endcase
    endfunction

    // ALU op for immediate forms
    function automatic ctrlPkg::aluOpE iAluOp(input isaPkg::opcodeE op);
        case (op)
            isaPkg::ADDI, isaPkg::ADDIU: return ctrlPkg::ALU_ADD;
            isaPkg::ANDI:                return ctrlPkg::ALU_AND;
            isaPkg::ORI:                 return ctrlPkg::ALU_OR;
            isaPkg::XORI:                return ctrlPkg::ALU_XOR;
            isaPkg::SLTI:                return ctrlPkg::ALU_SLT;
            isaPkg::SLTIU:               return ctrlPkg::ALU_SLTU;
            isaPkg::LUI:                 return ctrlPkg::ALU_LUI;
            default:                     return ctrlPkg::ALU_NONE;
        endcase
    endfunction

    ////////////////////
    // Field split
    ////////////////////

    assign opcode = isaPkg::opcodeE'(instrWord[isaPkg::OPCODE_LSB +: isaPkg::OPCODE_W]);
    assign funct = isaPkg::functE'(instrWord[isaPkg::FUNCT_LSB +: isaPkg::FUNCT_W]);
    assign srcA = instrWord[isaPkg::RS_LSB +: `REG_ADDR_W];
    assign srcB = instrWord[isaPkg::RT_LSB +: `REG_ADDR_W];
    assign rdField = instrWord[isaPkg::RD_LSB +: `REG_ADDR_W];
    // Shifts take only rt as a register operand
    assign isShift = (funct == isaPkg::SLL) || (funct == isaPkg::SRL) ||
                     (funct == isaPkg::SRA);

    ////////////////////
    // Main decoder
    ////////////////////

    always_comb begin
        ctrl = '0;
        usesA = 1'b0;
        usesB = 1'b0;
        readsHilo = 1'b0;
        case (opcode)
            isaPkg::R_TYPE: begin
                case (funct)
                    // HI/LO reads into rd
                    isaPkg::MFHI, isaPkg::MFLO: begin
                        ctrl.regWrite = 1'b1;
                        ctrl.regDst = 1'b1;
                        ctrl.retSrc = 1'b1;
                        ctrl.hilotoReg = (funct == isaPkg::MFHI);
                        readsHilo = 1'b1;
                    end
                    // rs moved into HI or LO
                    isaPkg::MTHI, isaPkg::MTLO: begin
                        ctrl.hiloWrite = 1'b1;
                        ctrl.hilotoReg = (funct == isaPkg::MTHI);
                        ctrl.hiloSrc = 1'b1;
                        usesA = 1'b1;
                    end
                    isaPkg::MULT, isaPkg::MULTU: begin
                        ctrl.hiloWrite = 1'b1;
                        ctrl.aluOp = (funct == isaPkg::MULT) ? ctrlPkg::ALU_MULT :
                                                               ctrlPkg::ALU_MULTU;
                        usesA = 1'b1;
                        usesB = 1'b1;
                    end
                    default: begin
                        ctrl.regWrite = 1'b1;
                        ctrl.regDst = 1'b1;
                        ctrl.aluSrc = 1'b1;
                        ctrl.aluOp = rAluOp(funct);
                        usesA = !isShift;
                        usesB = 1'b1;
                    end
                endcase
            end
            isaPkg::ANDI, isaPkg::XORI, isaPkg::ORI, isaPkg::LUI,
            isaPkg::ADDI, isaPkg::ADDIU, isaPkg::SLTI, isaPkg::SLTIU: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc = 1'b1;
                ctrl.aluOp = iAluOp(opcode);
                // LUI ignores rs
                usesA = (opcode != isaPkg::LUI);
            end
            isaPkg::LW: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc = 1'b1;
                ctrl.memRead = 1'b1;
                ctrl.memtoReg = 1'b1;
                ctrl.aluOp = ctrlPkg::ALU_ADD;
                usesA = 1'b1;
            end
            isaPkg::SW: begin
                ctrl.aluSrc = 1'b1;
                ctrl.memWrite = 1'b1;
                ctrl.aluOp = ctrlPkg::ALU_ADD;
                usesA = 1'b1;
                usesB = 1'b1;
            end
            // Compare by subtract
            isaPkg::BEQ, isaPkg::BNE: begin
                ctrl.branch = 1'b1;
                ctrl.aluOp = ctrlPkg::ALU_SUB;
                usesA = 1'b1;
                usesB = 1'b1;
            end
            isaPkg::J: begin
                ctrl.jump = 1'b1;
            end
            default: begin
                ctrl.reservedInstr = 1'b1;
            end
        endcase
    end

    // Write target, zero when nothing is written
    assign destReg = !ctrl.regWrite ? '0 : (ctrl.regDst ? rdField : srcB);

endmodule

//--- source/bundleLatch.sv
`timescale 1ns/100ps
`include "decode_params.svh"

module bundleLatch (
    input  logic        clk,
    input  logic        reset,
    input  logic        inValid,
    input  logic [31:0] bundleWords [0:`LANES-1],
    input  logic        pending,
    output logic [31:0] heldWords [0:`LANES-1],
    output logic        held
);

    logic load;

    ////////////////////
    // Accept
    ////////////////////

    // Strobe only counts when the previous bundle is fully gone
    assign load = inValid && !held && !pending;

    // One cycle start pulse for the collector
    always_ff @(posedge clk) begin
        if (reset) begin
            held <= 1'b0;
        end else begin
            held <= load;
        end
    end

    ////////////////////
    // Word storage
    ////////////////////

    // Words stay put while issue runs, lanes keep decoding them
    always_ff @(posedge clk) begin
        if (load) begin
            heldWords <= bundleWords;
        end
    end

endmodule

//--- source/ctrlPkg.sv
`include "decode_params.svh"

package ctrlPkg;

    ////////////////////
    // ALU operation
    ////////////////////

    // Zero encoding is no operation, so a cleared word means idle
    typedef enum logic [3:0] {
        ALU_NONE  = 4'd0,
        ALU_ADD   = 4'd1,
        ALU_SUB   = 4'd2,
        ALU_AND   = 4'd3,
        ALU_OR    = 4'd4,
        ALU_XOR   = 4'd5,
        ALU_SLT   = 4'd6,
        ALU_SLTU  = 4'd7,
        ALU_LUI   = 4'd8,
        ALU_SHIFT = 4'd9,
        ALU_MULT  = 4'd10,
        ALU_MULTU = 4'd11
    } aluOpE;

    ////////////////////
    // Control word
    ////////////////////

    typedef struct packed {
        logic  regWrite;      // Write GPR file
        logic  regDst;        // 1 rd, 0 rt
        logic  aluSrc;
        logic  retSrc;        // Result from HI/LO
        logic  memWrite;
        logic  memRead;
        logic  memtoReg;
        logic  hiloWrite;
        logic  hilotoReg;     // 1 HI, 0 LO
        logic  hiloSrc;       // Move instruction feeds HI/LO
        logic  branch;
        logic  jump;
        logic  reservedInstr; // Unknown opcode
        aluOpE aluOp;
    } ctrlWordT;

    // One bit per lane, lane 0 in bit 0
    typedef logic [`LANES-1:0] laneMaskT;

endpackage

//--- source/isaPkg.sv
package isaPkg;

    ////////////////////
    // Field positions
    ////////////////////

    // Major opcode in the top six bits
    localparam int OPCODE_LSB = 26;
    localparam int OPCODE_W = 6;
    localparam int RS_LSB = 21;
    localparam int RT_LSB = 16;
    localparam int RD_LSB = 11;
    // Function field, R-type only
    localparam int FUNCT_LSB = 0;
    localparam int FUNCT_W = 6;

    ////////////////////
    // Major opcodes
    ////////////////////

    typedef enum logic [5:0] {
        R_TYPE = 6'h00,
        J      = 6'h02,
        BEQ    = 6'h04,
        BNE    = 6'h05,
        ADDI   = 6'h08,
        ADDIU  = 6'h09,
        SLTI   = 6'h0a,
        SLTIU  = 6'h0b,
        ANDI   = 6'h0c,
        ORI    = 6'h0d,
        XORI   = 6'h0e,
        LUI    = 6'h0f,
        LW     = 6'h23,
        SW     = 6'h2b
    } opcodeE;

    // Function codes under R_TYPE
    typedef enum logic [5:0] {
        SLL   = 6'h00,
        SRL   = 6'h02,
        SRA   = 6'h03,
        MFHI  = 6'h10,
        MTHI  = 6'h11,
        MFLO  = 6'h12,
        MTLO  = 6'h13,
        MULT  = 6'h18,
        MULTU = 6'h19,
        ADD   = 6'h20,
        ADDU  = 6'h21,
        SUB   = 6'h22,
        SUBU  = 6'h23,
        AND   = 6'h24,
        OR    = 6'h25,
        XOR   = 6'h26,
        SLT   = 6'h2a,
        SLTU  = 6'h2b
    } functE;

endpackage

//--- include/decode_params.svh
`ifndef DECODE_PARAMS_SVH
`define DECODE_PARAMS_SVH

////////////////////
// Bundle geometry
////////////////////

// Instruction words per fetch bundle
`define LANES 2

// GPR address width, 32 registers
`define REG_ADDR_W 5

`endif
